/* hw/kinpira_settings.svh */
`ifndef KINPIRA_SETTINGS_SVH
`define KINPIRA_SETTINGS_SVH

// Datapath widths
`define KP_DWIDTH   16
`define KP_IMGSIZE  12
`define KP_NETSIZE  12
`define KP_LWIDTH   10
`define KP_ACC_W    48

// Quantization shift applied to the accumulator
`define KP_FRAC     8

// Register map
`define KP_REG_AW          5
`define KP_REG_WHICH       5'd0
`define KP_REG_REQ         5'd1
`define KP_REG_IN_OFFSET   5'd2
`define KP_REG_OUT_OFFSET  5'd3
`define KP_REG_NET_OFFSET  5'd4
`define KP_REG_TOTAL_OUT   5'd5
`define KP_REG_TOTAL_IN    5'd6
`define KP_REG_ACK         5'd30
`define KP_REG_WHICH_Q     5'd31

`endif

/* hw/kinpira_pkg.sv */
`default_nettype none

`include "kinpira_settings.svh"

package kinpira_pkg;

  typedef logic signed [`KP_DWIDTH-1:0] data_t;
  typedef logic [`KP_IMGSIZE-1:0]       img_addr_t;
  typedef logic [`KP_NETSIZE-1:0]       net_addr_t;
  typedef logic [`KP_LWIDTH-1:0]        len_t;
  typedef logic signed [`KP_ACC_W-1:0]  acc_t;
  typedef logic [`KP_REG_AW-1:0]        reg_addr_t;

  // Any other owner value leaves the memories idle
  typedef enum logic [1:0] {
    GOBOU  = 2'd1,
    NINJIN = 2'd2
  } owner_e;

  typedef enum logic [2:0] {
    IDLE, RUN, DRAIN, WRITE, NEXT, DONE
  } fc_state_e;

endpackage

`default_nettype wire

/* hw/mem_sp.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_sp #(
    parameter int DW = 16
  , parameter int AW = 12
) (
    input  logic          clk
  , input  logic          we
  , input  logic [AW-1:0] addr
  , input  logic [DW-1:0] wdata
  , output logic [DW-1:0] rdata
);

  logic [DW-1:0] mem [0:(2**AW)-1];

  // Read returns the old word on a same-cycle write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* hw/fc_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kinpira_settings.svh"

module fc_mac (
    input  logic               clk
  , input  logic               xrst
  , input  logic               clear
  , input  logic               en
  , input  kinpira_pkg::data_t pixel
  , input  kinpira_pkg::data_t weight
  , output kinpira_pkg::data_t result
);

  kinpira_pkg::acc_t acc;
  kinpira_pkg::acc_t product;

  // Sign-extend both operands to the accumulator width before the multiply
  assign product = kinpira_pkg::acc_t'(pixel) * kinpira_pkg::acc_t'(weight);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else if (en) begin
      acc <= acc + product;
    end
  end

  // Plain truncation that wraps on overflow
  assign result = acc[`KP_FRAC+`KP_DWIDTH-1:`KP_FRAC];

endmodule

`default_nettype wire

/* hw/kinpira_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kinpira_settings.svh"

module kinpira_ctrl (
    input  logic                   clk
  , input  logic                   xrst
  , input  logic                   reg_we
  , input  kinpira_pkg::reg_addr_t reg_addr
  , input  logic [31:0]            reg_wdata
  , output logic [31:0]            reg_rdata
  , input  logic                   img_we
  , input  kinpira_pkg::img_addr_t img_addr
  , input  kinpira_pkg::data_t     img_wdata
  , input  logic                   net_we
  , input  kinpira_pkg::net_addr_t net_addr
  , input  kinpira_pkg::data_t     net_wdata
  , output logic                   mem_img_we
  , output kinpira_pkg::img_addr_t mem_img_addr
  , output kinpira_pkg::data_t     mem_img_wdata
  , output logic                   mem_net_we
  , output kinpira_pkg::net_addr_t mem_net_addr
  , output kinpira_pkg::data_t     mem_net_wdata
  , output logic                   mac_clear
  , output logic                   mac_en
  , input  kinpira_pkg::data_t     mac_result
);

  logic [1:0]             which;
  logic [1:0]             which_q;
  logic                   req;
  kinpira_pkg::img_addr_t in_offset;
  kinpira_pkg::img_addr_t out_offset;
  kinpira_pkg::net_addr_t net_offset;
  kinpira_pkg::len_t      total_out;
  kinpira_pkg::len_t      total_in;

  kinpira_pkg::fc_state_e state;
  kinpira_pkg::len_t      in_cnt;
  kinpira_pkg::len_t      out_cnt;
  kinpira_pkg::net_addr_t w_ptr;

  logic                   host_own;
  logic                   core_own;
  logic                   ack;
  logic                   seq_img_we;
  kinpira_pkg::img_addr_t seq_img_addr;

  assign host_own = which == kinpira_pkg::NINJIN;
  assign core_own = which == kinpira_pkg::GOBOU;

  // Register bank
  always_ff @(posedge clk) begin
    if (!xrst) begin
      which      <= '0;
      which_q    <= '0;
      req        <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else begin
      which_q <= which;
      if (reg_we) begin
        case (reg_addr)
          `KP_REG_WHICH:      which      <= reg_wdata[1:0];
          `KP_REG_REQ:        req        <= reg_wdata[0];
          `KP_REG_IN_OFFSET:  in_offset  <= reg_wdata[`KP_IMGSIZE-1:0];
          `KP_REG_OUT_OFFSET: out_offset <= reg_wdata[`KP_IMGSIZE-1:0];
          `KP_REG_NET_OFFSET: net_offset <= reg_wdata[`KP_NETSIZE-1:0];
          `KP_REG_TOTAL_OUT:  total_out  <= reg_wdata[`KP_LWIDTH-1:0];
          `KP_REG_TOTAL_IN:   total_in   <= reg_wdata[`KP_LWIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_addr)
      `KP_REG_WHICH:      reg_rdata = 32'(which);
      `KP_REG_REQ:        reg_rdata = 32'(req);
      `KP_REG_IN_OFFSET:  reg_rdata = 32'(in_offset);
      `KP_REG_OUT_OFFSET: reg_rdata = 32'(out_offset);
      `KP_REG_NET_OFFSET: reg_rdata = 32'(net_offset);
      `KP_REG_TOTAL_OUT:  reg_rdata = 32'(total_out);
      `KP_REG_TOTAL_IN:   reg_rdata = 32'(total_in);
      `KP_REG_ACK:        reg_rdata = 32'(ack);
      `KP_REG_WHICH_Q:    reg_rdata = 32'(which_q);
      default:            reg_rdata = '0;
    endcase
  end

  // Host always sees ack high while it owns the memories
  always_comb begin
    if (host_own) begin
      ack = 1'b1;
    end else if (core_own) begin
      ack = state == kinpira_pkg::DONE;
    end else begin
      ack = 1'b0;
    end
  end

  // Layer sequencer
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= kinpira_pkg::IDLE;
      in_cnt    <= '0;
      out_cnt   <= '0;
      w_ptr     <= '0;
      mac_clear <= 1'b0;
      mac_en    <= 1'b0;
    end else begin
      mac_clear <= 1'b0;
      // Read data lands one cycle after the address
      mac_en    <= state == kinpira_pkg::RUN;
      case (state)
        kinpira_pkg::IDLE: begin
          if (req && core_own) begin
            in_cnt  <= '0;
            out_cnt <= '0;
            w_ptr   <= net_offset;
            if (total_in == '0 || total_out == '0) begin
              state <= kinpira_pkg::DONE;
            end else begin
              state     <= kinpira_pkg::RUN;
              mac_clear <= 1'b1;
            end
          end
        end
        kinpira_pkg::RUN: begin
          in_cnt <= in_cnt + 1'b1;
          // Weights for consecutive outputs are contiguous
          w_ptr  <= w_ptr + 1'b1;
          if (in_cnt == total_in - 1'b1) begin
            state <= kinpira_pkg::DRAIN;
          end
        end
        kinpira_pkg::DRAIN: begin
          state <= kinpira_pkg::WRITE;
        end
        kinpira_pkg::WRITE: begin
          state     <= kinpira_pkg::NEXT;
          mac_clear <= 1'b1;
        end
        kinpira_pkg::NEXT: begin
          in_cnt <= '0;
          if (out_cnt == total_out - 1'b1) begin
            state <= kinpira_pkg::DONE;
          end else begin
            out_cnt <= out_cnt + 1'b1;
            state   <= kinpira_pkg::RUN;
          end
        end
        kinpira_pkg::DONE: begin
          if (!req) begin
            state <= kinpira_pkg::IDLE;
          end
        end
        default: begin
          state <= kinpira_pkg::IDLE;
        end
      endcase
    end
  end

  assign seq_img_we   = state == kinpira_pkg::WRITE;
  assign seq_img_addr = seq_img_we ? out_offset + kinpira_pkg::img_addr_t'(out_cnt)
                                   : in_offset + kinpira_pkg::img_addr_t'(in_cnt);

  // No memory writes at all without a valid owner
  assign mem_img_we    = host_own ? img_we : (core_own & seq_img_we);
  assign mem_img_addr  = core_own ? seq_img_addr : img_addr;
  assign mem_img_wdata = core_own ? mac_result : img_wdata;

  // Core only reads weights
  assign mem_net_we    = host_own & net_we;
  assign mem_net_addr  = core_own ? w_ptr : net_addr;
  assign mem_net_wdata = net_wdata;

endmodule

`default_nettype wire

/* hw/kinpira_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kinpira_settings.svh"

module kinpira_top (
    input  logic                   clk
  , input  logic                   xrst
  , input  logic                   reg_we
  , input  kinpira_pkg::reg_addr_t reg_addr
  , input  logic [31:0]            reg_wdata
  , output logic [31:0]            reg_rdata
  , input  logic                   img_we
  , input  kinpira_pkg::img_addr_t img_addr
  , input  kinpira_pkg::data_t     img_wdata
  , output kinpira_pkg::data_t     img_rdata
  , input  logic                   net_we
  , input  kinpira_pkg::net_addr_t net_addr
  , input  kinpira_pkg::data_t     net_wdata
);

  logic                   mem_img_we;
  kinpira_pkg::img_addr_t mem_img_addr;
  kinpira_pkg::data_t     mem_img_wdata;

  logic                   mem_net_we;
  kinpira_pkg::net_addr_t mem_net_addr;
  kinpira_pkg::data_t     mem_net_wdata;
  kinpira_pkg::data_t     net_rdata;

  logic                   mac_clear;
  logic                   mac_en;
  kinpira_pkg::data_t     mac_result;

  kinpira_ctrl u_ctrl (
    .clk           (clk),
    .xrst          (xrst),
    .reg_we        (reg_we),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .img_we        (img_we),
    .img_addr      (img_addr),
    .img_wdata     (img_wdata),
    .net_we        (net_we),
    .net_addr      (net_addr),
    .net_wdata     (net_wdata),
    .mem_img_we    (mem_img_we),
    .mem_img_addr  (mem_img_addr),
    .mem_img_wdata (mem_img_wdata),
    .mem_net_we    (mem_net_we),
    .mem_net_addr  (mem_net_addr),
    .mem_net_wdata (mem_net_wdata),
    .mac_clear     (mac_clear),
    .mac_en        (mac_en),
    .mac_result    (mac_result)
  );

  // Image memory shared by host and core
  mem_sp #(
    .DW (`KP_DWIDTH),
    .AW (`KP_IMGSIZE)
  ) u_img_mem (
    .clk   (clk),
    .we    (mem_img_we),
    .addr  (mem_img_addr),
    .wdata (mem_img_wdata),
    .rdata (img_rdata)
  );

  mem_sp #(
    .DW (`KP_DWIDTH),
    .AW (`KP_NETSIZE)
  ) u_net_mem (
    .clk   (clk),
    .we    (mem_net_we),
    .addr  (mem_net_addr),
    .wdata (mem_net_wdata),
    .rdata (net_rdata)
  );

  fc_mac u_mac (
    .clk    (clk),
    .xrst   (xrst),
    .clear  (mac_clear),
    .en     (mac_en),
    .pixel  (img_rdata),
    .weight (net_rdata),
    .result (mac_result)
  );

endmodule

`default_nettype wire

/* dv/tb_kinpira.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kinpira_settings.svh"

module tb_kinpira;

  logic                   clk;
  logic                   xrst;
  logic                   reg_we;
  kinpira_pkg::reg_addr_t reg_addr;
  logic [31:0]            reg_wdata;
  logic [31:0]            reg_rdata;
  logic                   img_we;
  kinpira_pkg::img_addr_t img_addr;
  kinpira_pkg::data_t     img_wdata;
  kinpira_pkg::data_t     img_rdata;
  logic                   net_we;
  kinpira_pkg::net_addr_t net_addr;
  kinpira_pkg::data_t     net_wdata;

  integer             seed;
  int                 cycles;
  int                 limit;
  int                 n_in [0:6];
  int                 n_out [0:6];
  int                 in_off [0:6];
  int                 out_off [0:6];
  int                 net_off [0:6];
  kinpira_pkg::data_t img_model [0:4095];
  kinpira_pkg::data_t net_model [0:4095];

  kinpira_top kinpira_top_i (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .img_we    (img_we),
    .img_addr  (img_addr),
    .img_wdata (img_wdata),
    .img_rdata (img_rdata),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata)
  );

  always #5 clk = ~clk;

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout waiting for ack");
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [31:0] field_mask(input int r);
    if (r >= 5) begin
      return (32'd1 << `KP_LWIDTH) - 32'd1;
    end else if (r == 4) begin
      return (32'd1 << `KP_NETSIZE) - 32'd1;
    end
    return (32'd1 << `KP_IMGSIZE) - 32'd1;
  endfunction

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_reg(input kinpira_pkg::reg_addr_t addr, input logic [31:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input kinpira_pkg::reg_addr_t addr, output logic [31:0] data);
    reg_addr = addr;
    #1;
    data = reg_rdata;
    @(negedge clk);
  endtask

  task automatic write_img(input int addr, input kinpira_pkg::data_t data);
    img_we    = 1'b1;
    img_addr  = kinpira_pkg::img_addr_t'(addr);
    img_wdata = data;
    @(negedge clk);
    img_we = 1'b0;
  endtask

  task automatic write_net(input int addr, input kinpira_pkg::data_t data);
    net_we    = 1'b1;
    net_addr  = kinpira_pkg::net_addr_t'(addr);
    net_wdata = data;
    @(negedge clk);
    net_we = 1'b0;
  endtask

  task automatic check_img(input string name, input int addr);
    img_addr = kinpira_pkg::img_addr_t'(addr);
    @(negedge clk);
    check(name, 32'(img_model[addr]), 32'(img_rdata));
  endtask

  task automatic run_layer(input int k);
    kinpira_pkg::data_t v;
    logic [31:0]        rd;
    longint             sum;
    for (int i = 0; i < n_in[k]; i++) begin
      v = kinpira_pkg::data_t'($random(seed));
      img_model[in_off[k] + i] = v;
      write_img(in_off[k] + i, v);
    end
    for (int i = 0; i < n_out[k] * n_in[k]; i++) begin
      v = kinpira_pkg::data_t'($random(seed));
      net_model[net_off[k] + i] = v;
      write_net(net_off[k] + i, v);
    end
    // Output window plus one guard word on each side
    for (int a = out_off[k] - 1; a <= out_off[k] + n_out[k]; a++) begin
      v = kinpira_pkg::data_t'($random(seed));
      img_model[a] = v;
      write_img(a, v);
    end
    write_reg(`KP_REG_IN_OFFSET, 32'(in_off[k]));
    write_reg(`KP_REG_OUT_OFFSET, 32'(out_off[k]));
    write_reg(`KP_REG_NET_OFFSET, 32'(net_off[k]));
    write_reg(`KP_REG_TOTAL_OUT, 32'(n_out[k]));
    write_reg(`KP_REG_TOTAL_IN, 32'(n_in[k]));
    write_reg(`KP_REG_WHICH, 32'(kinpira_pkg::GOBOU));
    read_reg(`KP_REG_ACK, rd);
    check($sformatf("layer %0d ack before start", k), 32'd0, rd);
    // Core owns the memories, so these must be dropped
    write_img(in_off[k], ~img_model[in_off[k]]);
    write_net(net_off[k], ~net_model[net_off[k]]);
    write_reg(`KP_REG_REQ, 32'd1);
    rd = '0;
    while (rd[0] !== 1'b1) begin
      read_reg(`KP_REG_ACK, rd);
    end
    write_reg(`KP_REG_REQ, 32'd0);
    write_reg(`KP_REG_WHICH, 32'(kinpira_pkg::NINJIN));
    for (int o = 0; o < n_out[k]; o++) begin
      sum = '0;
      for (int i = 0; i < n_in[k]; i++) begin
        sum += longint'(img_model[in_off[k] + i]) *
               longint'(net_model[net_off[k] + o * n_in[k] + i]);
      end
      img_model[out_off[k] + o] = kinpira_pkg::data_t'(sum >>> `KP_FRAC);
    end
    for (int a = out_off[k] - 1; a <= out_off[k] + n_out[k]; a++) begin
      check_img($sformatf("layer %0d image word %0d", k, a), a);
    end
    check_img($sformatf("layer %0d input word", k), in_off[k]);
  endtask

  initial begin
    logic [31:0] vals [2:6];
    logic [31:0] rd;
    int          a;
    seed      = 62;
    clk       = 1'b0;
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    cycles    = 0;
    limit     = 2000;
    // Layer 5 is empty and layer 6 repeats the shape of layer 0
    for (int k = 0; k < 7; k++) begin
      n_in[k]    = (k == 6) ? n_in[0] : rand_range(1, 40);
      n_out[k]   = (k == 5) ? 0 : ((k == 6) ? n_out[0] : rand_range(1, 8));
      in_off[k]  = rand_range(0, 2000);
      out_off[k] = rand_range(2100, 4000);
      net_off[k] = rand_range(0, 3700);
      limit      = limit + 4 * n_out[k] * (n_in[k] + 6);
    end
    repeat (8) @(negedge clk);
    xrst = 1'b1;

    // All writes land before any readback
    for (int r = 2; r <= 6; r++) begin
      vals[r] = $random(seed);
      write_reg(kinpira_pkg::reg_addr_t'(r), vals[r]);
    end
    for (int r = 2; r <= 6; r++) begin
      read_reg(kinpira_pkg::reg_addr_t'(r), rd);
      check($sformatf("register %0d readback", r), vals[r] & field_mask(r), rd);
    end
    write_reg(`KP_REG_WHICH, 32'(kinpira_pkg::NINJIN));
    read_reg(`KP_REG_WHICH_Q, rd);
    check("registered which before update", 32'd0, rd);
    read_reg(`KP_REG_WHICH, rd);
    check("which readback", 32'(kinpira_pkg::NINJIN), rd);
    read_reg(`KP_REG_WHICH_Q, rd);
    check("registered which", 32'(kinpira_pkg::NINJIN), rd);

    for (int n = 0; n < 8; n++) begin
      a = rand_range(0, 4095);
      img_model[a] = kinpira_pkg::data_t'($random(seed));
      write_img(a, img_model[a]);
      check_img($sformatf("host image word %0d", a), a);
    end
    read_reg(`KP_REG_ACK, rd);
    check("ack while host owns", 32'd1, rd);

    for (int k = 0; k < 7; k++) begin
      run_layer(k);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* kinpira_top.f */
+incdir+hw
hw/kinpira_pkg.sv
hw/mem_sp.sv
hw/fc_mac.sv
hw/kinpira_ctrl.sv
hw/kinpira_top.sv
dv/tb_kinpira.sv

/* Makefile */
TOP = tb_kinpira

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f kinpira_top.f --top-module kinpira_top

sim:
	verilator --binary --timing -f kinpira_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
